/* verilog.f */
+incdir+include
design/remap_pkg.sv
design/bank_sram.sv
design/remap_cfg_regs.sv
design/bank_read_sched.sv
design/butterfly_write.sv
design/remap_cache.sv
tests/remap_cache_asserts.sv
tests/remap_cache_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run, the exit status carries the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f \
	--top-module remap_cache_tb -o remap_cache_sim &&
./obj_dir/remap_cache_sim ||
{ echo "remap_cache simulation did not pass"; exit 1; }

/* tests/remap_cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "remap_defines.svh"

module remap_cache_tb import remap_pkg::*; ();

	localparam int VSIZE = `REMAP_VSIZE;
	localparam int LBW   = `REMAP_LBW;
	localparam int CVBW  = `REMAP_CVBW;
	localparam int NCFG  = `REMAP_NCFG;
	localparam int NROW  = 1 << `REMAP_HBW;
	localparam int CLK_PERIOD = 100;
	localparam int SEED  = 49180;
	localparam int N_RAND = 40;
	localparam int N_CONF = 8;
	localparam int N_BP   = 30;
	// Rough operation count with 50 cycles of slack each
	localparam int TEST_OPS = 4 * NCFG + NROW + 2 * N_RAND + N_CONF + 2 * N_BP + 8;

	logic     i_clk = 1'b0;
	logic     i_rst_n;
	wb_req_t  i_wb;
	wb_rsp_t  o_wb;
	logic     i_ra_rdy;
	logic     o_ra_ack;
	rd_req_t  i_ra;
	logic     o_rd_rdy;
	logic     i_rd_ack;
	rd_resp_t o_rd;
	logic     i_wad_dval;
	wr_req_t  i_wad;

	// Shadow state of the scratchpad by bank and row
	word_t    shadow_mem [VSIZE][NROW];
	bank_t    shadow_mask [NCFG];
	// Expected data, expected P and accepting edge per outstanding read
	rd_resp_t exp_q [$];
	int       exp_p_q [$];
	int       acc_q [$];
	int       cyc_cnt = 0;
	int       n_issued = 0;
	int       n_done = 0;
	logic     bp_en = 1'b0;
	logic     rdy_prev = 1'b0;

	remap_cache dut (.*);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	always @(posedge i_clk) cyc_cnt <= cyc_cnt + 1;

	// Response acceptor stalls at random while back-pressure is on
	always @(posedge i_clk) begin
		#1;
		i_rd_ack = bp_en ? ($urandom_range(3, 0) == 0) : 1'b1;
	end

	// ==================================================
	// Failure reporting and compares
	// ==================================================

	task automatic report_fail(input string line);
		$display("%s", line);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare_resp(input rd_resp_t got, input rd_resp_t exp);
		if (got !== exp)
			report_fail($sformatf("Fail at %0d ns: read data %h, expected %h", $time, got, exp));
	endtask

	task automatic compare_wb(input word_t got, input word_t exp);
		if (got !== exp)
			report_fail($sformatf("Fail at %0d ns: mask readback %h, expected %h",
				$time, got, exp));
	endtask

	task automatic compare_latency(input int got, input int exp);
		if (got != exp)
			report_fail($sformatf("Fail at %0d ns: o_rd_rdy after %0d cycles, expected %0d",
				$time, got, exp));
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	// Expected lane words and worst bank conflict count
	function automatic rd_resp_t ref_read(input rd_req_t req, output int p);
		rd_resp_t r;
		int       cnt [VSIZE];
		bank_t    lo;
		bank_t    bk;
		row_t     row;
		r = '0;
		p = 0;
		for (int b = 0; b < VSIZE; b++) cnt[b] = 0;
		for (int l = 0; l < VSIZE; l++) begin
			lo  = req.addr[l][CVBW-1:0];
			row = req.addr[l][LBW-1:CVBW];
			// Bank is low bits XOR masked low row bits
			bk  = lo ^ (row[CVBW-1:0] & shadow_mask[req.id]);
			r.data[l] = shadow_mem[bk][row];
			cnt[bk]++;
		end
		for (int b = 0; b < VSIZE; b++) begin
			if (cnt[b] > p) p = cnt[b];
		end
		return r;
	endfunction

	// ==================================================
	// Stimulus tasks
	// ==================================================

	task automatic wb_cycle(input logic we, input cfg_id_t id, input word_t wdat,
			output word_t rdat);
		@(posedge i_clk);
		#1;
		i_wb = '{cyc: 1'b1, stb: 1'b1, we: we, adr: id, dat: wdat};
		@(negedge i_clk);
		while (!o_wb.ack) @(negedge i_clk);
		rdat = o_wb.dat;
		@(posedge i_clk);
		#1;
		i_wb = '0;
		@(negedge i_clk);
		// Single cycle ack pulse
		if (o_wb.ack) report_fail("Wishbone ack stayed high for more than one cycle");
		if (we) shadow_mask[id] = bank_t'(wdat[CVBW-1:0]);
	endtask

	task automatic write_row(input cfg_id_t id, input row_t row);
		wr_req_t w;
		bank_t   bk;
		w.id  = id;
		w.row = row;
		for (int j = 0; j < VSIZE; j++) begin
			w.data[j] = word_t'($urandom);
			// Word j goes to bank j XOR masked low row bits
			bk = bank_t'(j) ^ (row[CVBW-1:0] & shadow_mask[id]);
			shadow_mem[bk][row] = w.data[j];
		end
		@(posedge i_clk);
		#1;
		i_wad      = w;
		i_wad_dval = 1'b1;
		@(posedge i_clk);
		#1;
		i_wad_dval = 1'b0;
	endtask

	// Issue one vector and wait until its response is taken
	task automatic issue_read(input rd_req_t req);
		rd_resp_t exp;
		int       p;
		exp = ref_read(req, p);
		@(posedge i_clk);
		#1;
		i_ra     = req;
		i_ra_rdy = 1'b1;
		exp_q.push_back(exp);
		exp_p_q.push_back(p);
		@(negedge i_clk);
		while (!o_ra_ack) @(negedge i_clk);
		acc_q.push_back(cyc_cnt + 1);
		n_issued++;
		@(posedge i_clk);
		#1;
		i_ra_rdy = 1'b0;
		while (n_done != n_issued) @(negedge i_clk);
	endtask

	function automatic rd_req_t rand_req(input cfg_id_t id);
		rd_req_t r;
		r.id = id;
		for (int l = 0; l < VSIZE; l++) r.addr[l] = LBW'($urandom);
		return r;
	endfunction

	// Every lane lands in bank tgt from a random row
	function automatic rd_req_t same_bank_req(input cfg_id_t id, input bank_t tgt);
		rd_req_t r;
		row_t    row;
		r.id = id;
		for (int l = 0; l < VSIZE; l++) begin
			row = row_t'($urandom);
			r.addr[l] = {row, tgt ^ (row[CVBW-1:0] & shadow_mask[id])};
		end
		return r;
	endfunction

	// ==================================================
	// Response checker
	// ==================================================

	always @(negedge i_clk) begin
		if (i_rst_n) begin
			if (acc_q.size() > 0 && cyc_cnt >= acc_q[0] && o_ra_ack)
				report_fail("o_ra_ack went high before the response was taken");
			if (o_rd_rdy) begin
				if (exp_q.size() == 0) begin
					report_fail("Response presented with no read outstanding");
				end else begin
					// Rising edge of o_rd_rdy sets the latency
					if (!rdy_prev) compare_latency(cyc_cnt - acc_q[0], exp_p_q[0] + 1);
					compare_resp(o_rd, exp_q[0]);
					if (i_rd_ack) begin
						void'(exp_q.pop_front());
						void'(exp_p_q.pop_front());
						void'(acc_q.pop_front());
						n_done++;
					end
				end
			end
			rdy_prev = o_rd_rdy && !i_rd_ack;
		end
	end

	initial begin
		#(TEST_OPS * 50 * CLK_PERIOD);
		report_fail("Watchdog expired, the tests did not finish in time");
	end

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		word_t   rd;
		word_t   wd;
		rd_req_t req;
		row_t    row;
		void'($urandom(SEED));
		i_rst_n    = 1'b0;
		i_wb       = '0;
		i_ra_rdy   = 1'b0;
		i_ra       = '0;
		i_rd_ack   = 1'b0;
		i_wad_dval = 1'b0;
		i_wad      = '0;
		for (int i = 0; i < NCFG; i++) shadow_mask[i] = '0;
		repeat (8) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;

		// Reset state and cleared masks
		@(negedge i_clk);
		if (o_ra_ack !== 1'b1 || o_rd_rdy !== 1'b0 || o_wb.ack !== 1'b0)
			report_fail($sformatf("Fail at %0d ns: handshake outputs wrong after reset", $time));
		for (int i = 0; i < NCFG; i++) begin
			wb_cycle(1'b0, cfg_id_t'(i), '0, rd);
			compare_wb(rd, '0);
		end

		// Mask write and readback per id
		for (int i = 0; i < NCFG; i++) begin
			wd = word_t'($urandom);
			wb_cycle(1'b1, cfg_id_t'(i), wd, rd);
			wb_cycle(1'b0, cfg_id_t'(i), '0, rd);
			compare_wb(rd, word_t'(wd[CVBW-1:0]));
		end
		for (int i = 0; i < NCFG; i++) wb_cycle(1'b1, cfg_id_t'(i), '0, rd);

		// Fill every row and read one row back with mask zero
		for (int r = 0; r < NROW; r++) write_row('0, row_t'(r));
		row = row_t'($urandom);
		write_row('0, row);
		req.id = '0;
		for (int l = 0; l < VSIZE; l++) req.addr[l] = {row, bank_t'(l)};
		issue_read(req);

		// Nonzero masks on ids above zero with random traffic
		for (int i = 1; i < NCFG; i++)
			wb_cycle(1'b1, cfg_id_t'(i), word_t'($urandom_range(VSIZE - 1, 1)), rd);
		for (int i = 0; i < N_RAND; i++) begin
			write_row(cfg_id_t'($urandom), row_t'($urandom));
			issue_read(rand_req(cfg_id_t'($urandom)));
		end

		// Conflicting vectors in one bank, on one address and in pairs
		for (int i = 0; i < N_CONF; i++)
			issue_read(same_bank_req(cfg_id_t'($urandom), bank_t'($urandom)));
		req = rand_req(cfg_id_t'($urandom));
		for (int l = 1; l < VSIZE; l++) req.addr[l] = req.addr[0];
		issue_read(req);
		req = rand_req('0);
		for (int l = 0; l < VSIZE; l++) req.addr[l][CVBW-1:0] = bank_t'(l / 2);
		issue_read(req);

		// Back-pressure on the response
		bp_en = 1'b1;
		for (int i = 0; i < N_BP; i++) begin
			write_row(cfg_id_t'($urandom), row_t'($urandom));
			issue_read(rand_req(cfg_id_t'($urandom)));
		end
		repeat (4) @(negedge i_clk);

		// Scheduler accepts again once the last response is taken
		if (o_ra_ack !== 1'b1) begin
			report_fail("o_ra_ack stayed low after the last response was taken");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tests/remap_cache_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

`include "remap_defines.svh"

module remap_cache_asserts import remap_pkg::*; (
	input  wire      i_clk,
	input  wire      i_rst_n,
	input  wb_req_t  i_wb,
	input  wb_rsp_t  o_wb,
	input  wire      o_ra_ack,
	input  wire      o_rd_rdy,
	input  wire      i_rd_ack,
	input  rd_resp_t o_rd
);

	// ==================================================
	// Read response handshake
	// ==================================================

	// Held response keeps its data until taken
	a_rd_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_rd_rdy && !i_rd_ack) |=> (o_rd_rdy && $stable(o_rd)))
		else $error("o_rd or o_rd_rdy changed under back-pressure");

	// One vector at a time, no accept while a response waits
	a_no_accept: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_rd_rdy |-> !o_ra_ack)
		else $error("o_ra_ack high while a response is pending");

	// ==================================================
	// Wishbone
	// ==================================================

	// Ack only inside an active strobe
	a_wb_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_wb.ack |-> (i_wb.cyc && i_wb.stb))
		else $error("Wishbone ack without cyc and stb");

endmodule

bind remap_cache remap_cache_asserts u_asserts (
	.i_clk    (i_clk),
	.i_rst_n  (i_rst_n),
	.i_wb     (i_wb),
	.o_wb     (o_wb),
	.o_ra_ack (o_ra_ack),
	.o_rd_rdy (o_rd_rdy),
	.i_rd_ack (i_rd_ack),
	.o_rd     (o_rd)
);

`default_nettype wire

/* design/remap_cache.sv */
`timescale 1ns/10ps
`default_nettype none

`include "remap_defines.svh"

module remap_cache import remap_pkg::*; (
	input  wire      i_clk,
	input  wire      i_rst_n,
	input  wb_req_t  i_wb,
	output wb_rsp_t  o_wb,
	input  wire      i_ra_rdy,
	output logic     o_ra_ack,
	input  rd_req_t  i_ra,
	output logic     o_rd_rdy,
	input  wire      i_rd_ack,
	output rd_resp_t o_rd,
	input  wire      i_wad_dval,
	input  wr_req_t  i_wad
);

	// ==================================================
	// Interconnect
	// ==================================================

	bank_t [`REMAP_NCFG-1:0]   mask_table;
	logic  [`REMAP_VSIZE-1:0]  sram_re;
	row_t  [`REMAP_VSIZE-1:0]  sram_raddr;
	word_t [`REMAP_VSIZE-1:0]  sram_rdata;
	word_t [`REMAP_VSIZE-1:0]  sram_wdata;

	// Mask registers on Wishbone
	remap_cfg_regs u_cfg (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_wb         (i_wb),
		.o_wb         (o_wb),
		.o_mask_table (mask_table)
	);

	// Conflict resolving read side
	bank_read_sched u_rd (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_ra_rdy     (i_ra_rdy),
		.o_ra_ack     (o_ra_ack),
		.i_ra         (i_ra),
		.o_rd_rdy     (o_rd_rdy),
		.i_rd_ack     (i_rd_ack),
		.o_rd         (o_rd),
		.i_mask_table (mask_table),
		.o_sram_re    (sram_re),
		.o_sram_raddr (sram_raddr),
		.i_sram_rdata (sram_rdata)
	);

	// Row permutation for writes
	butterfly_write u_wr (
		.i_wad        (i_wad),
		.i_mask_table (mask_table),
		.o_bank_wdata (sram_wdata)
	);

	// ==================================================
	// Banks
	// ==================================================

	// All banks write the same row
	for (genvar gb = 0; gb < `REMAP_VSIZE; gb++) begin : g_bank
		bank_sram u_sram (
			.i_clk   (i_clk),
			.i_we    (i_wad_dval),
			.i_waddr (i_wad.row),
			.i_wdata (sram_wdata[gb]),
			.i_re    (sram_re[gb]),
			.i_raddr (sram_raddr[gb]),
			.o_rdata (sram_rdata[gb])
		);
	end

endmodule

`default_nettype wire

/* design/butterfly_write.sv */
`timescale 1ns/10ps
`default_nettype none

`include "remap_defines.svh"

module butterfly_write import remap_pkg::*; (
	input  wr_req_t                   i_wad,
	input  bank_t [`REMAP_NCFG-1:0]   i_mask_table,
	output word_t [`REMAP_VSIZE-1:0]  o_bank_wdata
);

	localparam int VSIZE = `REMAP_VSIZE;
	localparam int CVBW  = `REMAP_CVBW;

	// Offset applied to every lane index
	bank_t xr;
	// Stage k has lanes swapped across bit k
	word_t [VSIZE-1:0] stg [CVBW+1];

	assign xr     = remap_bank(bank_t'(0), i_wad.row, i_mask_table[i_wad.id]);
	assign stg[0] = i_wad.data;

	// ==================================================
	// Butterfly stages
	// ==================================================

	// XOR by a constant splits into one conditional swap per bit
	for (genvar gk = 0; gk < CVBW; gk++) begin : g_stage
		for (genvar gi = 0; gi < VSIZE; gi++) begin : g_lane
			assign stg[gk+1][gi] = xr[gk] ? stg[gk][gi ^ (1 << gk)] : stg[gk][gi];
		end
	end

	// Lane j has landed in bank j ^ xr
	assign o_bank_wdata = stg[CVBW];

endmodule

`default_nettype wire

/* design/bank_read_sched.sv */
`timescale 1ns/10ps
`default_nettype none

`include "remap_defines.svh"

module bank_read_sched import remap_pkg::*; (
	input  wire                       i_clk,
	input  wire                       i_rst_n,
	input  wire                       i_ra_rdy,
	output logic                      o_ra_ack,
	input  rd_req_t                   i_ra,
	output logic                      o_rd_rdy,
	input  wire                       i_rd_ack,
	output rd_resp_t                  o_rd,
	input  bank_t [`REMAP_NCFG-1:0]   i_mask_table,
	output logic [`REMAP_VSIZE-1:0]   o_sram_re,
	output row_t [`REMAP_VSIZE-1:0]   o_sram_raddr,
	input  word_t [`REMAP_VSIZE-1:0]  i_sram_rdata
);

	localparam int VSIZE = `REMAP_VSIZE;

	// ==================================================
	// Lane decode at acceptance
	// ==================================================

	bank_t                   ra_mask;
	bank_t [VSIZE-1:0]       ra_bank;
	row_t  [VSIZE-1:0]       ra_row;
	logic                    acc;
	logic                    take;

	// Handshakes
	assign acc  = i_ra_rdy && o_ra_ack;
	assign take = o_rd_rdy && i_rd_ack;

	assign ra_mask = i_mask_table[i_ra.id];

	always_comb begin
		for (int l = 0; l < VSIZE; l++) begin
			// Row is the high address part
			ra_row[l]  = i_ra.addr[l][`REMAP_LBW-1:`REMAP_CVBW];
			ra_bank[l] = remap_bank(i_ra.addr[l][`REMAP_CVBW-1:0], ra_row[l], ra_mask);
		end
	end

	// ==================================================
	// State
	// ==================================================

	logic                    busy_q;
	logic                    rdy_q;
	logic [VSIZE-1:0]        pend_q;
	logic [VSIZE-1:0]        fill_vld_q;
	bank_t [VSIZE-1:0]       fill_lane_q;
	bank_t [VSIZE-1:0]       lane_bank_q;
	row_t  [VSIZE-1:0]       lane_row_q;
	rd_resp_t                data_q;

	// Per pass grant
	logic [VSIZE-1:0]        sram_re;
	row_t  [VSIZE-1:0]       sram_raddr;
	bank_t [VSIZE-1:0]       gnt_lane;
	logic [VSIZE-1:0]        grant;
	logic                    land;

	// Each bank takes its lowest pending lane
	always_comb begin
		sram_re    = '0;
		sram_raddr = '0;
		gnt_lane   = '0;
		grant      = '0;
		for (int b = 0; b < VSIZE; b++) begin
			// Descending scan leaves the lowest match written last
			for (int l = VSIZE - 1; l >= 0; l--) begin
				if (pend_q[l] && lane_bank_q[l] == bank_t'(b)) begin
					sram_re[b]    = 1'b1;
					sram_raddr[b] = lane_row_q[l];
					gnt_lane[b]   = bank_t'(l);
				end
			end
		end
		// Lanes served this pass
		for (int b = 0; b < VSIZE; b++) begin
			if (sram_re[b]) begin
				grant[gnt_lane[b]] = 1'b1;
			end
		end
	end

	// Last pass data arrives while nothing is pending
	assign land = ~|pend_q && |fill_vld_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy_q     <= 1'b0;
			rdy_q      <= 1'b0;
			pend_q     <= '0;
			fill_vld_q <= '0;
		end else begin
			// One vector in flight from accept to take
			if (acc) begin
				busy_q <= 1'b1;
			end else if (take) begin
				busy_q <= 1'b0;
			end
			pend_q     <= acc ? '1 : (pend_q & ~grant);
			// Banks returning data next cycle
			fill_vld_q <= sram_re;
			if (land) begin
				rdy_q <= 1'b1;
			end else if (take) begin
				rdy_q <= 1'b0;
			end
		end
	end

	// Lane map and grant record
	always_ff @(posedge i_clk) begin
		if (acc) begin
			lane_bank_q <= ra_bank;
			lane_row_q  <= ra_row;
		end
		fill_lane_q <= gnt_lane;
	end

	// Collect words into lane order
	always_ff @(posedge i_clk) begin
		for (int b = 0; b < VSIZE; b++) begin
			if (fill_vld_q[b]) begin
				data_q.data[fill_lane_q[b]] <= i_sram_rdata[b];
			end
		end
	end

	assign o_ra_ack     = ~busy_q;
	assign o_rd_rdy     = rdy_q;
	assign o_rd         = data_q;
	assign o_sram_re    = sram_re;
	assign o_sram_raddr = sram_raddr;

endmodule

`default_nettype wire

/* design/remap_cfg_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "remap_defines.svh"

module remap_cfg_regs import remap_pkg::*; (
	input  wire                       i_clk,
	input  wire                       i_rst_n,
	input  wb_req_t                   i_wb,
	output wb_rsp_t                   o_wb,
	output bank_t [`REMAP_NCFG-1:0]   o_mask_table
);

	// ==================================================
	// Registers
	// ==================================================

	bank_t [`REMAP_NCFG-1:0] mask_q;
	logic                    ack_q;
	word_t                   rdat_q;
	logic                    wb_hit;

	// New strobe, ignored during the ack cycle
	assign wb_hit = i_wb.cyc && i_wb.stb && !ack_q;

	// ==================================================
	// Bus decode
	// ==================================================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mask_q <= '0;
			ack_q  <= 1'b0;
		end else begin
			// Ack lasts exactly one cycle
			ack_q <= wb_hit;
			// Address picks the config id, low data bits hold the mask
			if (wb_hit && i_wb.we) begin
				mask_q[i_wb.adr] <= i_wb.dat[`REMAP_CVBW-1:0];
			end
		end
	end

	// Readback data, launched with the ack
	always_ff @(posedge i_clk) begin
		if (wb_hit) begin
			rdat_q <= word_t'(mask_q[i_wb.adr]);
		end
	end

	assign o_wb.ack     = ack_q;
	assign o_wb.dat     = rdat_q;
	// Masks go straight to the read and write paths
	assign o_mask_table = mask_q;

endmodule

`default_nettype wire

/* design/bank_sram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "remap_defines.svh"

module bank_sram import remap_pkg::*; (
	input  wire   i_clk,
	input  wire   i_we,
	input  row_t  i_waddr,
	input  word_t i_wdata,
	input  wire   i_re,
	input  row_t  i_raddr,
	output word_t o_rdata
);

	localparam int NROW = 1 << `REMAP_HBW;

	// One word per row
	word_t mem [NROW];

	// Write port
	always_ff @(posedge i_clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// Read port, one cycle latency
	// Output keeps the last read word while re is low
	always_ff @(posedge i_clk) begin
		if (i_re) begin
			o_rdata <= mem[i_raddr];
		end
	end

endmodule

`default_nettype wire

/* design/remap_pkg.sv */
`default_nettype none

`include "remap_defines.svh"

package remap_pkg;

	// ==================================================
	// Scalar types
	// ==================================================

	// Bank or lane index
	typedef logic [`REMAP_CVBW-1:0] bank_t;
	// Row within one bank
	typedef logic [`REMAP_HBW-1:0] row_t;
	typedef logic [`REMAP_CFGBW-1:0] cfg_id_t;
	typedef logic [`REMAP_DBW-1:0] word_t;

	// ==================================================
	// Bundles
	// ==================================================

	// Read request, VSIZE local addresses under one config id
	typedef struct packed {
		cfg_id_t id;
		logic [`REMAP_VSIZE-1:0][`REMAP_LBW-1:0] addr;
	} rd_req_t;

	// Read response, words in lane order
	typedef struct packed {
		word_t [`REMAP_VSIZE-1:0] data;
	} rd_resp_t;

	// Full row write, words in lane order
	typedef struct packed {
		cfg_id_t id;
		row_t row;
		word_t [`REMAP_VSIZE-1:0] data;
	} wr_req_t;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		cfg_id_t adr;
		word_t dat;
	} wb_req_t;

	// Wishbone classic, slave to master
	typedef struct packed {
		logic ack;
		word_t dat;
	} wb_rsp_t;

	// Bank select: low address bits XOR masked low row bits
	function automatic bank_t remap_bank(input bank_t lo, input row_t row, input bank_t mask);
		return lo ^ (row[`REMAP_CVBW-1:0] & mask);
	endfunction

endpackage

`default_nettype wire

/* include/remap_defines.svh */
`ifndef REMAP_DEFINES_SVH
`define REMAP_DEFINES_SVH

// ==================================================
// Scratchpad geometry
// ==================================================

// Lanes per vector, also the bank count
`define REMAP_VSIZE 4
// Local address width, bank bits plus row bits
`define REMAP_LBW 8
// Data word width
`define REMAP_DBW 16
// Configuration ids, one XOR mask each
`define REMAP_NCFG 4

// Derived widths
`define REMAP_CVBW $clog2(`REMAP_VSIZE)
`define REMAP_HBW (`REMAP_LBW - `REMAP_CVBW)
`define REMAP_CFGBW $clog2(`REMAP_NCFG)

`endif
